/* Makefile */
# Verilator simulation of the MSR memory controller

VERILATOR ?= verilator
TOP       ?= memCtrlTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, and pass only when the testbench reports a pass
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJDIR)

/* bench/memModel.svh */
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// Expected reply for one slot
typedef struct packed {
   logic  ack;
   logic  nxm;
   word_t data;
} reply_t;

// LFSR state and reference copy of array and MSR
logic [31:0] lfsrState = 32'h665eb1ef;
word_t modelMem [0:MEM_WORDS-1];
logic  memWritten [0:MEM_WORDS-1] = '{default: 1'b0};
logic  modelPE = 1'b0;
logic  modelEE = 1'b1;
logic  modelPF = 1'b1;
int    errorCount = 0;

// Galois LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [35:0] randBits(input int n);
   logic [35:0] val;
   int i;
   val = '0;
   for (i = 0; i < n; i++)
   begin
      val = {val[34:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
   end
   return val;
endfunction

// Applies one request in issue order and returns its reply
function automatic reply_t modelApply(input busReq_t req);
   reply_t r;
   r = '0;
   if (!req.io && req.addr >= 20'd1024)
      r.nxm = 1'b1;
   else if (!req.io)
   begin
      r.ack = 1'b1;
      if (req.read)
         r.data = modelMem[req.addr[10:19]];
      else
      begin
         modelMem[req.addr[10:19]] = req.data;
         memWritten[req.addr[10:19]] = 1'b1;
      end
   end
   else if (req.addr == MSR_ADDR)
   begin
      r.ack = 1'b1;
      // Read word holds PE, EE and PF only
      if (req.read)
      begin
         r.data[MSR_PE] = modelPE;
         r.data[MSR_EE] = modelEE;
         r.data[MSR_PF] = modelPF;
      end
      else
      begin
         modelPE = req.data[MSR_PE];
         modelEE = !req.data[MSR_ED];
         // PF can be cleared but never set again
         if (!req.data[MSR_PF])
            modelPF = 1'b0;
      end
   end
   // Foreign IO leaves r empty, no reply
   return r;
endfunction

task automatic compareValue(input string name, input word_t actual, input word_t expected);
   if (actual !== expected)
   begin
      $display("Mismatch at %0t: %s is %o, expected %o", $time, name, actual, expected);
      errorCount++;
   end
endtask

`endif

/* bench/memCtrlTb.sv */
`timescale 1ns/1ps

module memCtrlTb;

   import memPkg::*;

   localparam int RESET_CYCLES   = 8;
   localparam int DIRECTED_SLOTS = 60;
   localparam int RANDOM_REQS    = 300;
   // Random requests take at most three slots each, plus drain and slack
   localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_SLOTS + 3 * RANDOM_REQS + 50;

   logic    clk = 1'b0;
   logic    rst;
   logic    busREQ;
   busReq_t busIN;
   logic    busACK;
   logic    busNXM;
   word_t   busOUT;

   `include "memModel.svh"

   // One entry per slot, oldest first
   reply_t pending [$];
   int     cycleCount = 0;

   memCtrl u_dut (
      .clk    (clk),
      .rst    (rst),
      .busREQ (busREQ),
      .busIN  (busIN),
      .busACK (busACK),
      .busNXM (busNXM),
      .busOUT (busOUT)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Request helpers
   //////////////////////////////////////////////////

   function automatic busReq_t makeRequest(input logic isRead, input logic isIo,
                                           input addr_t addr, input word_t data);
      busReq_t r;
      r.read  = isRead;
      r.write = !isRead;
      r.io    = isIo;
      r.addr  = addr;
      r.data  = data;
      return r;
   endfunction

   function automatic word_t msrData(input logic pe, input logic pf, input logic ed);
      word_t w;
      w = '0;
      w[MSR_PE] = pe;
      w[MSR_PF] = pf;
      w[MSR_ED] = ed;
      return w;
   endfunction

   // Check the reply from three slots back, then drive this slot
   task automatic driveSlot(input logic strobe, input busReq_t req);
      reply_t want;
      @(negedge clk);
      if (pending.size() == 3)
      begin
         want = pending.pop_front();
         compareValue("busACK", word_t'(busACK), word_t'(want.ack));
         compareValue("busNXM", word_t'(busNXM), word_t'(want.nxm));
         compareValue("busOUT", busOUT, want.data);
      end
      busREQ = strobe;
      busIN  = req;
      if (strobe)
         pending.push_back(modelApply(req));
      else
         pending.push_back(reply_t'(0));
   endtask

   task automatic sendRequest(input busReq_t req);
      driveSlot(1'b1, req);
   endtask

   task automatic idleSlot();
      driveSlot(1'b0, busReq_t'(0));
   endtask

   // MSR write followed by a read-back
   task automatic msrWriteRead(input logic pe, input logic pf, input logic ed);
      sendRequest(makeRequest(1'b0, 1'b1, MSR_ADDR, msrData(pe, pf, ed)));
      sendRequest(makeRequest(1'b1, 1'b1, MSR_ADDR, '0));
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial
   begin : stimulus
      addr_t       dirAddr [0:7];
      addr_t       addr;
      word_t       data;
      logic [35:0] kind;
      logic        isRead;
      int          n;
      rst    = 1'b1;
      busREQ = 1'b0;
      busIN  = '0;
      repeat (RESET_CYCLES) idleSlot();
      rst = 1'b0;

      // MSR after reset, EE and PF set
      sendRequest(makeRequest(1'b1, 1'b1, MSR_ADDR, '0));

      // PE, then ED both ways, then PF clear and no re-set
      msrWriteRead(1'b1, 1'b1, 1'b0);
      msrWriteRead(1'b1, 1'b1, 1'b1);
      msrWriteRead(1'b0, 1'b1, 1'b0);
      msrWriteRead(1'b0, 1'b0, 1'b0);
      msrWriteRead(1'b1, 1'b1, 1'b0);
      sendRequest(makeRequest(1'b0, 1'b1, MSR_ADDR, '1));
      sendRequest(makeRequest(1'b1, 1'b1, MSR_ADDR, '0));

      // Back-to-back writes, then reads
      for (n = 0; n < 8; n++)
      begin
         dirAddr[n] = 20'(randBits(10));
         data = randBits(36);
         sendRequest(makeRequest(1'b0, 1'b0, dirAddr[n], data));
      end
      for (n = 0; n < 8; n++)
         sendRequest(makeRequest(1'b1, 1'b0, dirAddr[n], '0));

      // Read right behind the write to the same word
      for (n = 0; n < 2; n++)
      begin
         addr = 20'(randBits(10));
         data = randBits(36);
         sendRequest(makeRequest(1'b0, 1'b0, addr, data));
         sendRequest(makeRequest(1'b1, 1'b0, addr, '0));
      end

      // Decode edges, foreign IO between replying requests
      addr = 20'(randBits(10));
      data = randBits(36);
      sendRequest(makeRequest(1'b0, 1'b0, addr, data));
      sendRequest(makeRequest(1'b1, 1'b1, MSR_ADDR + 20'd1, '0));
      sendRequest(makeRequest(1'b1, 1'b0, addr, '0));
      sendRequest(makeRequest(1'b1, 1'b0, 20'd1024, '0));
      sendRequest(makeRequest(1'b0, 1'b1, 20'd5, data));
      sendRequest(makeRequest(1'b0, 1'b0, 20'hfffff, data));
      sendRequest(makeRequest(1'b1, 1'b1, MSR_ADDR, '0));

      // Random mix, about three strobes in four slots
      for (n = 0; n < RANDOM_REQS; n++)
      begin
         if (randBits(2) == 36'd0)
         begin
            idleSlot();
            if (randBits(1) == 36'd1)
               idleSlot();
         end
         kind   = randBits(3);
         isRead = (randBits(1) == 36'd1);
         data   = randBits(36);
         case (kind[2:0])
            3'd4: sendRequest(makeRequest(isRead, 1'b0, 20'd1024 + 20'(randBits(19)), data));
            3'd5: sendRequest(makeRequest(isRead, 1'b1, MSR_ADDR, data));
            3'd6:
            begin
               addr = 20'(randBits(20));
               if (addr == MSR_ADDR)
                  addr = addr ^ 20'd1;
               sendRequest(makeRequest(isRead, 1'b1, addr, data));
            end
            default:
            begin
               // Half of it on 16 words so reads find data
               if (randBits(1) == 36'd1)
                  addr = 20'(randBits(4));
               else
                  addr = 20'(randBits(10));
               // Never read a word that holds nothing yet
               if (!memWritten[addr[10:19]])
                  isRead = 1'b0;
               sendRequest(makeRequest(isRead, 1'b0, addr, data));
            end
         endcase
      end

      // Drain the last three replies
      repeat (3) idleSlot();
      $display("Errors: %0d mismatches after %0d cycles", errorCount, cycleCount);
      if (errorCount == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   //////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////

   initial
   begin : watchdog
      while (cycleCount < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d mismatches after %0d cycles", errorCount, cycleCount);
      $display("** FAIL **");
      $finish;
   end

endmodule

/* source/memArray.sv */
`timescale 1ns/1ps

module memArray (
   input  logic             clk,
   input  logic             rst,
   input  memPkg::memCmd_t  cmd,
   output memPkg::memRslt_t rslt
);

   import memPkg::*;

   // Word storage, contents survive reset
   word_t mem [0:MEM_WORDS-1];

   // Strobe into the status register
   logic msrWrite;

   // Current MSR read-back
   word_t regStat;

   //////////////////////////////////////////////////
   // Memory Status Register
   //////////////////////////////////////////////////

   assign msrWrite = (cmd.op == OP_MSRWR);

   memStat u_stat (
      .clk      (clk),
      .rst      (rst),
      .busDATAI (cmd.data),
      .msrWrite (msrWrite),
      .regStat  (regStat)
   );

   //////////////////////////////////////////////////
   // Array write
   //////////////////////////////////////////////////

   // Written at this edge, a read in the next slot sees it
   always_ff @(posedge clk)
   begin
      if (cmd.op == OP_MEMWR)
         mem[cmd.index] <= cmd.data;
   end

   //////////////////////////////////////////////////
   // Result register
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         rslt.op <= OP_NONE;
      else
         rslt.op <= cmd.op;
      // Only reads carry data forward
      case (cmd.op)
         OP_MEMRD: rslt.data <= mem[cmd.index];
         OP_MSRRD: rslt.data <= regStat;
         default:  rslt.data <= '0;
      endcase
   end

endmodule

/* source/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl (
   input  logic            clk,
   input  logic            rst,
   input  logic            busREQ,
   input  memPkg::busReq_t busIN,
   output logic            busACK,
   output logic            busNXM,
   output memPkg::word_t   busOUT
);

   import memPkg::*;

   // Decode to execute
   memCmd_t cmd;

   // Execute to respond
   memRslt_t rslt;

   //////////////////////////////////////////////////
   // Stage 1, decode
   //////////////////////////////////////////////////

   memDecode u_decode (
      .clk    (clk),
      .rst    (rst),
      .busREQ (busREQ),
      .busIN  (busIN),
      .cmd    (cmd)
   );

   //////////////////////////////////////////////////
   // Stage 2, execute
   //////////////////////////////////////////////////

   // Array and MSR
   memArray u_array (
      .clk  (clk),
      .rst  (rst),
      .cmd  (cmd),
      .rslt (rslt)
   );

   //////////////////////////////////////////////////
   // Stage 3, respond
   //////////////////////////////////////////////////

   // Replies land three clocks after the request
   memRespond u_respond (
      .clk    (clk),
      .rst    (rst),
      .rslt   (rslt),
      .busACK (busACK),
      .busNXM (busNXM),
      .busOUT (busOUT)
   );

endmodule

/* source/memDecode.sv */
`timescale 1ns/1ps

module memDecode (
   input  logic            clk,
   input  logic            rst,
   input  logic            busREQ,
   input  memPkg::busReq_t busIN,
   output memPkg::memCmd_t cmd
);

   import memPkg::*;

   // Classified operation for this cycle
   memOp_t nextOp;

   // Address falls inside the populated array
   logic inArray;

   // Address hits the MSR
   logic isMsr;

   //////////////////////////////////////////////////
   // Request classification
   //////////////////////////////////////////////////

   assign inArray = (busIN.addr < MEM_WORDS);
   assign isMsr   = (busIN.addr == MSR_ADDR);

   always_comb
   begin
      // No strobe means an empty slot
      nextOp = OP_NONE;
      if (busREQ)
      begin
         if (!busIN.io)
         begin
            // Memory space, past the array is nonexistent
            if (inArray)
               nextOp = busIN.read ? OP_MEMRD : OP_MEMWR;
            else
               nextOp = OP_NXM;
         end
         else if (isMsr)
         begin
            nextOp = busIN.read ? OP_MSRRD : OP_MSRWR;
         end
         // Foreign IO address stays OP_NONE, no reply
      end
   end

   //////////////////////////////////////////////////
   // Command register
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         cmd.op <= OP_NONE;
      else
         cmd.op <= nextOp;
      // Low address bits select the array word
      cmd.index <= busIN.addr[$bits(addr_t)-MEM_AWIDTH +: MEM_AWIDTH];
      cmd.data  <= busIN.data;
   end

endmodule

/* source/memPkg.sv */
package memPkg;

   //////////////////////////////////////////////////
   // Sizes and addresses
   //////////////////////////////////////////////////

   // Array index bits, 1024 words of storage
   localparam int MEM_AWIDTH = 10;
   localparam int MEM_WORDS = 1 << MEM_AWIDTH;

   // KS10 word, bit 0 is the MSB
   typedef logic [0:35] word_t;

   // Physical or IO address, bit 0 is the MSB
   typedef logic [0:19] addr_t;

   // IO address of the Memory Status Register
   localparam addr_t MSR_ADDR = 20'o100000;

   // MSR field positions inside a word
   localparam int MSR_PE = 3;
   localparam int MSR_EE = 4;
   localparam int MSR_PF = 12;
   localparam int MSR_ED = 35;

   //////////////////////////////////////////////////
   // Pipeline types
   //////////////////////////////////////////////////

   // Decoded operation, OP_NONE marks an empty slot
   typedef enum logic [2:0] {
      OP_NONE  = 3'd0,
      OP_MEMRD = 3'd1,
      OP_MEMWR = 3'd2,
      OP_MSRRD = 3'd3,
      OP_MSRWR = 3'd4,
      OP_NXM   = 3'd5
   } memOp_t;

   // Bus request as seen at the pins
   typedef struct packed {
      logic  read;
      logic  write;
      logic  io;
      addr_t addr;
      word_t data;
   } busReq_t;

   // Decode to execute
   typedef struct packed {
      memOp_t                op;
      logic [0:MEM_AWIDTH-1] index;
      word_t                 data;
   } memCmd_t;

   // Execute to respond
   typedef struct packed {
      memOp_t op;
      word_t  data;
   } memRslt_t;

endpackage

/* source/memRespond.sv */
`timescale 1ns/1ps

module memRespond (
   input  logic             clk,
   input  logic             rst,
   input  memPkg::memRslt_t rslt,
   output logic             busACK,
   output logic             busNXM,
   output memPkg::word_t    busOUT
);

   import memPkg::*;

   // Op answered with an acknowledge
   logic isAck;

   // Op that returns data
   logic isRead;

   //////////////////////////////////////////////////
   // Strobe decode
   //////////////////////////////////////////////////

   assign isAck  = (rslt.op == OP_MEMRD) || (rslt.op == OP_MEMWR) ||
                   (rslt.op == OP_MSRRD) || (rslt.op == OP_MSRWR);
   assign isRead = (rslt.op == OP_MEMRD) || (rslt.op == OP_MSRRD);

   //////////////////////////////////////////////////
   // Bus outputs
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busACK <= 1'b0;
         busNXM <= 1'b0;
         busOUT <= '0;
      end
      else
      begin
         busACK <= isAck;
         // NXM never acknowledges
         busNXM <= (rslt.op == OP_NXM);
         // Bus idles at zero outside a read reply
         busOUT <= isRead ? rslt.data : '0;
      end
   end

endmodule

/* source/memStat.sv */
`timescale 1ns/1ps

module memStat (
   input  logic          clk,
   input  logic          rst,
   input  memPkg::word_t busDATAI,
   input  logic          msrWrite,
   output memPkg::word_t regStat
);

   import memPkg::*;

   // Parity error, plain read/write
   logic statPE;

   // ECC enable, inverse of last ED written
   logic statEE;

   // Power fail, set at reset
   logic statPF;

   //////////////////////////////////////////////////
   // Status flip-flops
   //////////////////////////////////////////////////

   // PE follows the written bit
   always_ff @(posedge clk)
   begin
      if (rst)
         statPE <= 1'b0;
      else if (msrWrite)
         statPE <= busDATAI[MSR_PE];
   end

   // PF only clears, writing a 1 keeps it
   always_ff @(posedge clk)
   begin
      if (rst)
         statPF <= 1'b1;
      else if (msrWrite)
         statPF <= statPF & busDATAI[MSR_PF];
   end

   // ED=1 disables ECC, so EE reads the inverse
   always_ff @(posedge clk)
   begin
      if (rst)
         statEE <= 1'b1;
      else if (msrWrite)
         statEE <= ~busDATAI[MSR_ED];
   end

   //////////////////////////////////////////////////
   // Read-back word
   //////////////////////////////////////////////////

   // EH, UE, RE, ECP, ERA and ED all read as zero
   always_comb
   begin
      regStat         = '0;
      regStat[MSR_PE] = statPE;
      regStat[MSR_EE] = statEE;
      regStat[MSR_PF] = statPF;
   end

endmodule

/* sources.f */
source/memPkg.sv
source/memDecode.sv
source/memStat.sv
source/memArray.sv
source/memRespond.sv
source/memCtrl.sv
bench/memCtrlTb.sv
+incdir+bench
